//--- hw/fe_bus_if.sv
// Front end pipeline buses
// fetch_bus_if links the PC generator to the IF/ID register,
// dec_bus_if links the IF/ID register to the decode stage

`timescale 1ns/100ps
`default_nettype none

interface fetch_bus_if import rv_fe_pkg::*; ();

    pc_t  pc;       // PC offered for fetch
    pc_t  pc_next;  // pc + 4
    logic valid;
    logic ready;    // Also the memory read enable
    logic flush;    // Redirect this cycle

    modport src  (output pc, pc_next, valid, input ready, flush);
    modport sink (input pc, pc_next, valid, flush, output ready);

endinterface

interface dec_bus_if import rv_fe_pkg::*; ();

    logic      valid;
    logic      ready;
    pc_t       pc;
    pc_t       pc_next;
    instr_t    instr;
    opcode_t   opcode;
    reg_addr_t rd;
    funct3_t   funct3;
    reg_addr_t rs1;
    reg_addr_t rs2;
    funct7_t   funct7;

    modport src (
        output valid, pc, pc_next, instr, opcode, rd, funct3, rs1, rs2, funct7,
        input  ready
    );
    modport sink (
        input  valid, pc, pc_next, instr, opcode, rd, funct3, rs1, rs2, funct7,
        output ready
    );

endinterface

`default_nettype wire

//--- hw/if_id_reg.sv
// IF/ID pipeline register
// Delays the fetched PC one stage to line up with the memory word, then
// registers PC, PC + 4, the instruction and its fixed fields

`timescale 1ns/100ps
`default_nettype none

module if_id_reg import rv_fe_pkg::*; (
    input  wire         clk,
    input  wire         i_rst,
    input  wire instr_t i_instr,     // Memory word, one cycle behind its PC
    fetch_bus_if.sink   fetch_bus,
    dec_bus_if.src      dec_bus
);

    pc_t  pc_s1;
    pc_t  pc_next_s1;
    logic valid_s1;  // PC stage matching the memory read in flight
    logic en;

    // Move when decode takes the item or the output stage is empty
    assign en              = dec_bus.ready || !dec_bus.valid;
    assign fetch_bus.ready = en;

    always_ff @(posedge clk) begin
        if (i_rst || fetch_bus.flush) begin
            valid_s1        <= 1'b0;
            pc_s1           <= '0;
            pc_next_s1      <= '0;
            dec_bus.valid   <= 1'b0;
            dec_bus.pc      <= '0;
            dec_bus.pc_next <= '0;
            dec_bus.instr   <= '0;
            dec_bus.opcode  <= '0;
            dec_bus.rd      <= '0;
            dec_bus.funct3  <= '0;
            dec_bus.rs1     <= '0;
            dec_bus.rs2     <= '0;
            dec_bus.funct7  <= '0;
        end else if (en) begin
            valid_s1        <= fetch_bus.valid;
            pc_s1           <= fetch_bus.pc;
            pc_next_s1      <= fetch_bus.pc_next;
            dec_bus.valid   <= valid_s1;
            dec_bus.pc      <= pc_s1;
            dec_bus.pc_next <= pc_next_s1;
            dec_bus.instr   <= i_instr;
            dec_bus.opcode  <= i_instr[6:0];
            dec_bus.rd      <= i_instr[11:7];
            dec_bus.funct3  <= i_instr[14:12];
            dec_bus.rs1     <= i_instr[19:15];
            dec_bus.rs2     <= i_instr[24:20];
            dec_bus.funct7  <= i_instr[31:25];
        end
    end

endmodule

`default_nettype wire

//--- hw/imem_rom.sv
// Instruction memory
// Word array with one registered read port and a loader write port

`timescale 1ns/100ps
`default_nettype none

`include "rv_fe_macros.svh"

module imem_rom import rv_fe_pkg::*; (
    input  wire             clk,
    input  wire             i_re,
    input  wire imem_addr_t i_raddr,
    output instr_t          o_rdata,
    input  wire             i_we,
    input  wire imem_addr_t i_waddr,
    input  wire instr_t     i_wdata
);

    instr_t mem [`RV_IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;  // Program load
        end
    end

    // Read data holds while the enable is low
    always_ff @(posedge clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

`default_nettype wire

//--- hw/inst_decode.sv
// RV32I decode stage
// Builds the sign-extended immediate for the opcode's format, flags
// unknown opcodes and registers the result behind a valid/ready port

`timescale 1ns/100ps
`default_nettype none

`include "rv_fe_macros.svh"

module inst_decode import rv_fe_pkg::*; (
    input  wire                clk,
    input  wire                i_rst,
    input  wire                i_flush,
    dec_bus_if.sink            dec_bus,
    output logic               o_valid,
    input  wire                i_ready,
    output pc_t                o_pc,
    output pc_t                o_pc_next,
    output reg_addr_t          o_rd,
    output reg_addr_t          o_rs1,
    output reg_addr_t          o_rs2,
    output funct3_t            o_funct3,
    output funct7_t            o_funct7,
    output opcode_t            o_opcode,
    output logic [`RV_XLEN-1:0] o_imm,
    output logic               o_illegal
);

    logic [`RV_XLEN-1:0] imm;
    logic                illegal;
    logic                en;
    instr_t              ins;

    assign ins = dec_bus.instr;

    always_comb begin
        imm     = '0;
        illegal = 1'b0;
        case (dec_bus.opcode)
            LOAD, OP_IMM, JALR, SYSTEM:
                imm = {{20{ins[31]}}, ins[31:20]};
            STORE:
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            BRANCH:
                imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            LUI, AUIPC:
                imm = {ins[31:12], 12'b0};
            JAL:
                imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            OP, MISC_MEM:
                imm = '0;  // No immediate field
            default:
                illegal = 1'b1;
        endcase
        if (dec_bus.opcode[1:0] != 2'b11) begin
            illegal = 1'b1;  // Compressed or reserved encoding
        end
    end

    // Output register loads when empty or being taken
    assign en            = i_ready || !o_valid;
    assign dec_bus.ready = en;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_valid <= 1'b0;  // Drop anything fetched before a redirect
        end else if (en) begin
            o_valid <= dec_bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            o_pc      <= dec_bus.pc;
            o_pc_next <= dec_bus.pc_next;
            o_rd      <= dec_bus.rd;
            o_rs1     <= dec_bus.rs1;
            o_rs2     <= dec_bus.rs2;
            o_funct3  <= dec_bus.funct3;
            o_funct7  <= dec_bus.funct7;
            o_opcode  <= dec_bus.opcode;
            o_imm     <= imm;
            o_illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

//--- hw/pc_gen.sv
// Program counter generator
// Advances by one word per accepted fetch, loads the redirect target
// on a flush and holds while the pipeline is stalled

`timescale 1ns/100ps
`default_nettype none

`include "rv_fe_macros.svh"

module pc_gen import rv_fe_pkg::*; (
    input  wire         clk,
    input  wire         i_rst,
    input  wire pc_t    i_redirect_pc,
    fetch_bus_if.src    fetch_bus
);

    pc_t pc_q;

    // Redirect wins over a stall
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc_q <= pc_t'(`RV_RESET_PC);
        end else if (fetch_bus.flush) begin
            pc_q <= i_redirect_pc;
        end else if (fetch_bus.valid && fetch_bus.ready) begin
            pc_q <= pc_q + pc_t'(4);  // Next sequential word
        end
    end

    assign fetch_bus.pc      = pc_q;
    assign fetch_bus.pc_next = pc_q + pc_t'(4);

    // A PC is on offer in every cycle outside reset, so the first
    // fetch goes out on the first edge after reset falls
    assign fetch_bus.valid = ~i_rst;

endmodule

`default_nettype wire

//--- hw/rv_fe_macros.svh
// RV32I front end build constants
// Instruction width, instruction memory size and the reset vector

`ifndef RV_FE_MACROS_SVH
`define RV_FE_MACROS_SVH

// Instruction and PC width
`define RV_XLEN 32

// Words in the instruction memory, PC bits 7:2 select one
`define RV_IMEM_DEPTH 64

// First PC fetched after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- hw/rv_fe_pkg.sv
// RV32I front end shared types
// Vector typedefs for the fetch and decode paths and the base ISA
// major opcode values

`default_nettype none

`include "rv_fe_macros.svh"

package rv_fe_pkg;

    typedef logic [`RV_XLEN-1:0] pc_t;
    typedef logic [`RV_XLEN-1:0] instr_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [6:0]          opcode_t;
    typedef logic [2:0]          funct3_t;
    typedef logic [6:0]          funct7_t;
    typedef logic [$clog2(`RV_IMEM_DEPTH)-1:0] imem_addr_t;  // Word address

    // RV32I major opcodes, instr[6:0]
    localparam opcode_t LUI      = 7'b0110111;
    localparam opcode_t AUIPC    = 7'b0010111;
    localparam opcode_t JAL      = 7'b1101111;
    localparam opcode_t JALR     = 7'b1100111;
    localparam opcode_t BRANCH   = 7'b1100011;
    localparam opcode_t LOAD     = 7'b0000011;
    localparam opcode_t STORE    = 7'b0100011;
    localparam opcode_t OP_IMM   = 7'b0010011;
    localparam opcode_t OP       = 7'b0110011;
    localparam opcode_t MISC_MEM = 7'b0001111;  // FENCE
    localparam opcode_t SYSTEM   = 7'b1110011;  // ECALL, EBREAK, CSR

endpackage

`default_nettype wire

//--- hw/rv_frontend_top.sv
// RV32I instruction front end
// PC generation, instruction memory, IF/ID register and decode, with a
// redirect input and a valid/ready decoded instruction output

`timescale 1ns/100ps
`default_nettype none

`include "rv_fe_macros.svh"

module rv_frontend_top import rv_fe_pkg::*; (
    input  wire                      clk,
    input  wire                      i_rst,
    input  wire                      i_imem_we,
    input  wire imem_addr_t          i_imem_waddr,
    input  wire instr_t              i_imem_wdata,
    input  wire                      i_redirect_valid,
    input  wire pc_t                 i_redirect_pc,
    input  wire                      i_dec_ready,
    output wire                      o_dec_valid,
    output wire pc_t                 o_dec_pc,
    output wire pc_t                 o_dec_pc_next,
    output wire reg_addr_t           o_dec_rd,
    output wire reg_addr_t           o_dec_rs1,
    output wire reg_addr_t           o_dec_rs2,
    output wire funct3_t             o_dec_funct3,
    output wire funct7_t             o_dec_funct7,
    output wire opcode_t             o_dec_opcode,
    output wire [`RV_XLEN-1:0]       o_dec_imm,
    output wire                      o_dec_illegal
);

    fetch_bus_if fetch_bus ();
    dec_bus_if   dec_bus ();

    imem_addr_t imem_raddr;
    instr_t     imem_rdata;

    assign fetch_bus.flush = i_redirect_valid;
    assign imem_raddr      = fetch_bus.pc[$bits(imem_addr_t)+1:2];  // Word address

    pc_gen pc_gen_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_redirect_pc (i_redirect_pc),
        .fetch_bus     (fetch_bus.src)
    );

    imem_rom imem_rom_i (
        .clk     (clk),
        .i_re    (fetch_bus.ready),
        .i_raddr (imem_raddr),
        .o_rdata (imem_rdata),
        .i_we    (i_imem_we),
        .i_waddr (i_imem_waddr),
        .i_wdata (i_imem_wdata)
    );

    if_id_reg if_id_reg_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_instr   (imem_rdata),
        .fetch_bus (fetch_bus.sink),
        .dec_bus   (dec_bus.src)
    );

    inst_decode inst_decode_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_flush   (i_redirect_valid),
        .dec_bus   (dec_bus.sink),
        .o_valid   (o_dec_valid),
        .i_ready   (i_dec_ready),
        .o_pc      (o_dec_pc),
        .o_pc_next (o_dec_pc_next),
        .o_rd      (o_dec_rd),
        .o_rs1     (o_dec_rs1),
        .o_rs2     (o_dec_rs2),
        .o_funct3  (o_dec_funct3),
        .o_funct7  (o_dec_funct7),
        .o_opcode  (o_dec_opcode),
        .o_imm     (o_dec_imm),
        .o_illegal (o_dec_illegal)
    );

endmodule

`default_nettype wire

//--- verif/rv_frontend_tb.sv
// Testbench for the RV32I instruction front end
// Loads a program table during reset, streams it through decode under
// random back-pressure with one redirect, and checks every output field

`timescale 1ns/100ps
`default_nettype none

`include "rv_fe_macros.svh"

module rv_frontend_tb import rv_fe_pkg::*; ();

    localparam int NUM_ROWS       = 24;
    localparam int JUMP_ROW       = 10;  // Redirect follows this row
    localparam int TARGET_ROW     = 4;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 + 100;

    logic       clk;
    logic       i_rst;
    logic       i_imem_we;
    imem_addr_t i_imem_waddr;
    instr_t     i_imem_wdata;
    logic       i_redirect_valid;
    pc_t        i_redirect_pc;
    logic       i_dec_ready;

    wire            o_dec_valid;
    wire pc_t       o_dec_pc;
    wire pc_t       o_dec_pc_next;
    wire reg_addr_t o_dec_rd;
    wire reg_addr_t o_dec_rs1;
    wire reg_addr_t o_dec_rs2;
    wire funct3_t   o_dec_funct3;
    wire funct7_t   o_dec_funct7;
    wire opcode_t   o_dec_opcode;
    wire [31:0]     o_dec_imm;
    wire            o_dec_illegal;

    // Program table: word, expected immediate, expected illegal flag
    instr_t      prog_word [NUM_ROWS];
    logic [31:0] prog_imm  [NUM_ROWS];
    logic        prog_ill  [NUM_ROWS];

    int          exp_q [$];  // Row indices in expected output order
    int          cycle_cnt;
    int          idx;
    int          row;
    int          n_taken;
    logic [31:0] rnd;
    logic        take;
    logic        stalled;
    logic        redirected;
    pc_t         held_pc;
    logic [31:0] held_imm;

    rv_frontend_top rv_frontend_top_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: program not drained after %0d cycles", cycle_cnt);
            $display("tests failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic set_row(input int r, input instr_t word, input logic [31:0] imm,
                           input logic ill);
        prog_word[r] = word;
        prog_imm[r]  = imm;
        prog_ill[r]  = ill;
    endtask

    task automatic load_table();
        set_row(0,  32'h00500093, 32'h00000005, 1'b0);  // addi x1, x0, 5
        set_row(1,  32'hFFF08113, 32'hFFFFFFFF, 1'b0);  // addi x2, x1, -1
        set_row(2,  32'h123451B7, 32'h12345000, 1'b0);  // lui x3
        set_row(3,  32'hFFFFF217, 32'hFFFFF000, 1'b0);  // auipc x4
        set_row(4,  32'h00812283, 32'h00000008, 1'b0);  // lw x5, 8(x2)
        set_row(5,  32'hFFC1A303, 32'hFFFFFFFC, 1'b0);  // lw x6, -4(x3)
        set_row(6,  32'h00512623, 32'h0000000C, 1'b0);  // sw x5, 12(x2)
        set_row(7,  32'hFE61AC23, 32'hFFFFFFF8, 1'b0);  // sw x6, -8(x3)
        set_row(8,  32'h00208863, 32'h00000010, 1'b0);  // beq x1, x2, +16
        set_row(9,  32'hFE419CE3, 32'hFFFFFFF8, 1'b0);  // bne x3, x4, -8
        set_row(10, 32'h001000EF, 32'h00000800, 1'b0);  // jal x1, +2048
        set_row(11, 32'hFFDFF06F, 32'hFFFFFFFC, 1'b0);  // jal x0, -4
        set_row(12, 32'h000280E7, 32'h00000000, 1'b0);  // jalr x1, 0(x5)
        set_row(13, 32'hFF008067, 32'hFFFFFFF0, 1'b0);  // jalr x0, -16(x1)
        set_row(14, 32'h006283B3, 32'h00000000, 1'b0);  // add x7, x5, x6
        set_row(15, 32'h40138433, 32'h00000000, 1'b0);  // sub x8, x7, x1
        set_row(16, 32'h0FF0000F, 32'h00000000, 1'b0);  // fence
        set_row(17, 32'h00000073, 32'h00000000, 1'b0);  // ecall
        set_row(18, 32'h00100073, 32'h00000001, 1'b0);  // ebreak
        set_row(19, 32'h4034D493, 32'h00000403, 1'b0);  // srai x9, x9, 3
        set_row(20, 32'hDEADB07F, 32'h00000000, 1'b1);  // Unknown opcode
        set_row(21, 32'h00004501, 32'h00000000, 1'b1);  // Low bits 01
        set_row(22, 32'h0000000B, 32'h00000000, 1'b1);  // custom-0
        set_row(23, 32'h7FF5F513, 32'h000007FF, 1'b0);  // andi x10, x11, 0x7ff
    endtask

    // Fields are fixed slices of the word, the PC follows the row index
    task automatic check_row(input int r);
        pc_t    exp_pc;
        instr_t w;
        exp_pc = pc_t'(`RV_RESET_PC + 4 * r);
        w      = prog_word[r];
        check_value($sformatf("row %0d pc", r), exp_pc, o_dec_pc);
        check_value($sformatf("row %0d pc_next", r), exp_pc + 4, o_dec_pc_next);
        check_value($sformatf("row %0d opcode", r), w[6:0], o_dec_opcode);
        check_value($sformatf("row %0d rd", r), w[11:7], o_dec_rd);
        check_value($sformatf("row %0d funct3", r), w[14:12], o_dec_funct3);
        check_value($sformatf("row %0d rs1", r), w[19:15], o_dec_rs1);
        check_value($sformatf("row %0d rs2", r), w[24:20], o_dec_rs2);
        check_value($sformatf("row %0d funct7", r), w[31:25], o_dec_funct7);
        check_value($sformatf("row %0d illegal", r), prog_ill[r], o_dec_illegal);
        if (!prog_ill[r]) begin
            check_value($sformatf("row %0d imm", r), prog_imm[r], o_dec_imm);
        end
    endtask

    initial begin
        i_rst            = 1'b1;
        i_imem_we        = 1'b0;
        i_imem_waddr     = '0;
        i_imem_wdata     = '0;
        i_redirect_valid = 1'b0;
        i_redirect_pc    = '0;
        i_dec_ready      = 1'b1;
        rnd              = 32'h21dfdcbf;
        stalled          = 1'b0;
        redirected       = 1'b0;
        n_taken          = 0;
        load_table();
        for (idx = 0; idx <= JUMP_ROW; idx++) exp_q.push_back(idx);
        for (idx = TARGET_ROW; idx < NUM_ROWS; idx++) exp_q.push_back(idx);

        // Reset spans the program load and 5 more cycles
        for (idx = 0; idx < NUM_ROWS; idx++) begin
            @(posedge clk);
            i_imem_we    <= 1'b1;
            i_imem_waddr <= imem_addr_t'((`RV_RESET_PC >> 2) + idx);
            i_imem_wdata <= prog_word[idx];
        end
        @(posedge clk);
        i_imem_we <= 1'b0;
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;
        @(negedge clk);
        check_value("valid after reset", 32'd0, o_dec_valid);

        while (exp_q.size() != 0) begin
            if (stalled) begin  // Outputs must not move while stalled
                check_value("hold valid", 32'd1, o_dec_valid);
                check_value("hold pc", held_pc, o_dec_pc);
                check_value("hold imm", held_imm, o_dec_imm);
            end
            stalled  = o_dec_valid && !i_dec_ready && !i_redirect_valid;
            held_pc  = o_dec_pc;
            held_imm = o_dec_imm;
            take     = o_dec_valid && i_dec_ready;
            if (take) begin
                row = exp_q.pop_front();
                check_row(row);
                n_taken++;
            end
            @(posedge clk);
            if (take && row == JUMP_ROW && !redirected) begin
                redirected = 1'b1;
                i_redirect_valid <= 1'b1;
                i_redirect_pc    <= pc_t'(`RV_RESET_PC + 4 * TARGET_ROW);
                i_dec_ready      <= 1'b0;  // Nothing taken on the flush edge
            end else begin
                rnd = xorshift32(rnd);
                i_redirect_valid <= 1'b0;
                i_dec_ready      <= (n_taken == 0) || (rnd[1:0] != 2'b00);
            end
            @(negedge clk);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/rv_fe_pkg.sv
hw/fe_bus_if.sv
hw/pc_gen.sv
hw/imem_rom.sv
hw/if_id_reg.sv
hw/inst_decode.sv
hw/rv_frontend_top.sv
verif/rv_frontend_tb.sv
